// ==== src/samcoupe_cfg.svh ====
`ifndef SAMCOUPE_CFG_SVH
`define SAMCOUPE_CFG_SVH

// ========================================
// Bus and datapath widths
// ========================================
`define SAMC_DATA_W        8
`define SAMC_ADDR_W        16
`define SAMC_PAGE_W        9
`define SAMC_AUDIO_W       16

// ========================================
// I/O port numbers, low address byte
// ========================================
`define SAMC_PORT_LMPR     8'hFA
`define SAMC_PORT_HMPR     8'hFB
`define SAMC_PORT_BRDR     8'hFE
`define SAMC_PORT_STAT     8'hF9
`define SAMC_PORT_MIDI     8'hFD
`define SAMC_PORT_LPTD     8'hE8
`define SAMC_PORT_LPTS     8'hE9
`define SAMC_PORT_EXTC     8'h80
`define SAMC_PORT_EXTD     8'h81

// MIDI timing, counted in 1 MHz ticks
`define SAMC_CE_1M_DIV     96
`define SAMC_TICK_W        7
`define SAMC_MIDI_TX_TICKS 319
`define SAMC_MIDI_INT_TICK 15
`define SAMC_TIMER_W       9

`endif

// ==== src/samcoupe_pkg.sv ====
`default_nettype none

package samcoupe_pkg;

	`include "samcoupe_cfg.svh"

	// ========================================
	// CPU I/O request
	// ========================================
	typedef struct packed {
		logic                    write;
		logic [`SAMC_ADDR_W-1:0] addr;
		logic [`SAMC_DATA_W-1:0] data;
	} io_req_t;

	// Low memory page register, port FA
	typedef struct packed {
		logic       write_protect;
		logic       rom1_on;
		logic       rom0_off;
		logic [4:0] page;
	} lmpr_t;

	// High memory page register, port FB
	typedef struct packed {
		logic       ext_ram;
		logic [1:0] mode3_hi;
		logic [4:0] page;
	} hmpr_t;

	// One written byte, seen as either paging register
	typedef union packed {
		lmpr_t lmpr;
		hmpr_t hmpr;
	} mpr_u;

	// Mapper result for the current CPU address
	typedef struct packed {
		logic [`SAMC_PAGE_W-1:0] page;
		logic                    rom0_sel;
		logic                    rom1_sel;
		logic                    write_protect;
	} mem_map_t;

	// Parallel port write strobes with their byte
	typedef struct packed {
		logic                    data_wr;
		logic                    stb_wr;
		logic [`SAMC_DATA_W-1:0] data;
	} lpt_wr_t;

endpackage

`default_nettype wire

// ==== src/asic_port_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module asic_port_regs
	import samcoupe_pkg::*;
(
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     io_req_valid,
	input  wire io_req_t            io_req,
	input  wire                     midi_pending,
	input  wire                     midi_int,
	output logic                    io_req_ready,
	output logic                    io_rsp_valid,
	output logic [`SAMC_DATA_W-1:0] io_rsp_data,
	output lmpr_t                   lmpr,
	output hmpr_t                   hmpr,
	output logic [`SAMC_DATA_W-1:0] ext_c,
	output logic [`SAMC_DATA_W-1:0] ext_d,
	output logic [3:0]              border_colour,
	output logic                    ear,
	output lpt_wr_t                 lpt_wr,
	output logic                    midi_wr
);

	logic [7:0]              port;
	logic                    sel_lmpr;
	logic                    sel_hmpr;
	logic                    sel_brdr;
	logic                    sel_stat;
	logic                    sel_midi;
	logic                    sel_lptd;
	logic                    sel_lpts;
	logic                    sel_extc;
	logic                    sel_extd;
	logic                    accept;
	logic                    wr_acc;
	logic                    rd_acc;
	mpr_u                    wr_mpr;
	logic [`SAMC_DATA_W-1:0] brdr;
	logic [`SAMC_DATA_W-1:0] rd_data;

	// ========================================
	// Decode and handshake
	// ========================================
	assign port     = io_req.addr[7:0];
	assign sel_lmpr = (port == `SAMC_PORT_LMPR);
	assign sel_hmpr = (port == `SAMC_PORT_HMPR);
	assign sel_brdr = (port == `SAMC_PORT_BRDR);
	assign sel_stat = (port == `SAMC_PORT_STAT);
	assign sel_midi = (port == `SAMC_PORT_MIDI);
	assign sel_lptd = (port == `SAMC_PORT_LPTD);
	assign sel_lpts = (port == `SAMC_PORT_LPTS);
	assign sel_extc = (port == `SAMC_PORT_EXTC);
	assign sel_extd = (port == `SAMC_PORT_EXTD);

	// MIDI byte waits while the previous one is still pending
	assign io_req_ready = !(io_req.write && sel_midi && midi_pending);
	assign accept       = io_req_valid && io_req_ready;
	assign wr_acc       = accept && io_req.write;
	assign rd_acc       = accept && !io_req.write;

	// Same byte viewed as LMPR or HMPR
	assign wr_mpr = io_req.data;

	// ========================================
	// Register storage
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr         <= '0;
			hmpr         <= '0;
			brdr         <= '0;
			io_rsp_valid <= 1'b0;
		end else begin
			io_rsp_valid <= rd_acc;
			if (wr_acc && sel_lmpr) begin
				lmpr <= wr_mpr.lmpr;
			end
			if (wr_acc && sel_hmpr) begin
				hmpr <= wr_mpr.hmpr;
			end
			if (wr_acc && sel_brdr) begin
				brdr <= io_req.data;
			end
		end
	end

	// External RAM pages and read data
	always_ff @(posedge clk_sys) begin
		if (wr_acc && sel_extc) begin
			ext_c <= io_req.data;
		end
		if (wr_acc && sel_extd) begin
			ext_d <= io_req.data;
		end
		if (rd_acc) begin
			io_rsp_data <= rd_data;
		end
	end

	// Read mux, unmapped ports float high
	always_comb begin
		rd_data = 8'hFF;
		if (sel_lmpr) begin
			rd_data = lmpr;
		end else if (sel_hmpr) begin
			rd_data = hmpr;
		end else if (sel_stat) begin
			// Only the MIDI interrupt is live, active low
			rd_data = {3'b111, ~midi_int, 4'b1111};
		end else if (sel_lptd || sel_lpts) begin
			rd_data = 8'h00;
		end
	end

	assign border_colour = {brdr[5], brdr[2:0]};
	assign ear           = brdr[4];

	// Strobes to the audio and MIDI blocks
	assign lpt_wr.data_wr = wr_acc && sel_lptd;
	assign lpt_wr.stb_wr  = wr_acc && sel_lpts;
	assign lpt_wr.data    = io_req.data;
	assign midi_wr        = wr_acc && sel_midi;

endmodule

`default_nettype wire

// ==== src/mem_page_map.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module mem_page_map
	import samcoupe_pkg::*;
(
	input  wire [`SAMC_ADDR_W-1:0] mem_addr,
	input  wire lmpr_t             lmpr,
	input  wire hmpr_t             hmpr,
	input  wire [`SAMC_DATA_W-1:0] ext_c,
	input  wire [`SAMC_DATA_W-1:0] ext_d,
	output mem_map_t               mem_map
);

	logic [1:0] quad;
	logic [4:0] lmpr_next;
	logic [4:0] hmpr_next;

	assign quad = mem_addr[15:14];

	// Odd quadrants use the following page, wraps within 32
	assign lmpr_next = lmpr.page + 5'd1;
	assign hmpr_next = hmpr.page + 5'd1;

	// ========================================
	// Page select per quadrant
	// ========================================
	always_comb begin
		if (hmpr.ext_ram && quad[1]) begin
			// External RAM covers the upper half
			mem_map.page = quad[0] ? {1'b1, ext_d} : {1'b1, ext_c};
		end else begin
			case (quad)
				2'd0:    mem_map.page = {4'd0, lmpr.page};
				2'd1:    mem_map.page = {4'd0, lmpr_next};
				2'd2:    mem_map.page = {4'd0, hmpr.page};
				default: mem_map.page = {4'd0, hmpr_next};
			endcase
		end
	end

	// ROM overlays and write protect
	always_comb begin
		mem_map.rom0_sel      = !lmpr.rom0_off && (quad == 2'd0);
		mem_map.rom1_sel      = lmpr.rom1_on && (quad == 2'd3);
		mem_map.write_protect = lmpr.write_protect && (quad == 2'd0);
	end

endmodule

`default_nettype wire

// ==== src/midi_tx_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module midi_tx_timer (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  midi_wr,
	output logic midi_pending,
	output logic midi_tx,
	output logic midi_int
);

	localparam logic [`SAMC_TIMER_W-1:0] TX_LOAD = `SAMC_MIDI_TX_TICKS;
	localparam logic [`SAMC_TIMER_W-1:0] INT_AT  = `SAMC_MIDI_INT_TICK;
	localparam logic [`SAMC_TICK_W-1:0]  DIV_END = `SAMC_CE_1M_DIV - 1;

	logic [`SAMC_TICK_W-1:0]  div_cnt;
	logic                     tick;
	logic [`SAMC_TIMER_W-1:0] tx_time;

	// ========================================
	// 1 MHz tick from clk_sys
	// ========================================
	assign tick = (div_cnt == DIV_END);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ========================================
	// Transmit timer
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_time      <= '0;
			midi_pending <= 1'b0;
			midi_tx      <= 1'b0;
			midi_int     <= 1'b0;
		end else begin
			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					// Interrupt near the end of the byte
					if (tx_time == INT_AT) begin
						midi_int <= 1'b1;
					end
				end else begin
					midi_tx  <= 1'b0;
					midi_int <= 1'b0;
					// Idle, start the waiting byte if any
					if (midi_pending) begin
						midi_tx      <= 1'b1;
						tx_time      <= TX_LOAD;
						midi_pending <= 1'b0;
					end
				end
			end
			if (midi_wr) begin
				midi_pending <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/lpt_dac_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module lpt_dac_mixer
	import samcoupe_pkg::*;
(
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire lpt_wr_t             lpt_wr,
	input  wire                      ear,
	output logic [`SAMC_AUDIO_W-1:0] audio_l,
	output logic [`SAMC_AUDIO_W-1:0] audio_r
);

	logic [`SAMC_DATA_W-1:0] lpt_data;
	logic [`SAMC_DATA_W-1:0] dac_l;
	logic [`SAMC_DATA_W-1:0] dac_r;
	logic                    old_stb;

	// DAC scaled near full range plus EAR at a quarter, then /8
	function automatic logic [`SAMC_AUDIO_W-1:0] mix_sample(
		input logic [`SAMC_DATA_W-1:0] dac,
		input logic                    ear_bit
	);
		logic [18:0] sum;
		sum = 19'(dac) * 19'd1028 + (ear_bit ? 19'd131072 : 19'd0);
		return sum[18:3];
	endfunction

	// ========================================
	// Parallel port latches
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lpt_data <= '0;
			dac_l    <= '0;
			dac_r    <= '0;
			old_stb  <= 1'b0;
		end else begin
			if (lpt_wr.data_wr) begin
				lpt_data <= lpt_wr.data;
			end
			if (lpt_wr.stb_wr) begin
				// Rising strobe loads left, falling loads right
				if (!old_stb && lpt_wr.data[0]) begin
					dac_l <= lpt_data;
				end
				if (old_stb && !lpt_wr.data[0]) begin
					dac_r <= lpt_data;
				end
				old_stb <= lpt_wr.data[0];
			end
		end
	end

	// Audio mix
	assign audio_l = mix_sample(dac_l, ear);
	assign audio_r = mix_sample(dac_r, ear);

endmodule

`default_nettype wire

// ==== src/samcoupe_asic.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module samcoupe_asic
	import samcoupe_pkg::*;
(
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           io_req_valid,
	input  wire io_req_t                  io_req,
	output logic                          io_req_ready,
	output logic                          io_rsp_valid,
	output logic [`SAMC_DATA_W-1:0]       io_rsp_data,
	input  wire  [`SAMC_ADDR_W-1:0]       mem_addr,
	output mem_map_t                      mem_map,
	output logic [3:0]                    border_colour,
	output logic [`SAMC_AUDIO_W-1:0]      audio_l,
	output logic [`SAMC_AUDIO_W-1:0]      audio_r,
	output logic                          midi_tx,
	output logic                          midi_int
);

	lmpr_t                   lmpr;
	hmpr_t                   hmpr;
	logic [`SAMC_DATA_W-1:0] ext_c;
	logic [`SAMC_DATA_W-1:0] ext_d;
	logic                    ear;
	lpt_wr_t                 lpt_wr;
	logic                    midi_wr;
	logic                    midi_pending;

	// Port decode and register file
	asic_port_regs u_port_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.io_req_valid  (io_req_valid),
		.io_req        (io_req),
		.midi_pending  (midi_pending),
		.midi_int      (midi_int),
		.io_req_ready  (io_req_ready),
		.io_rsp_valid  (io_rsp_valid),
		.io_rsp_data   (io_rsp_data),
		.lmpr          (lmpr),
		.hmpr          (hmpr),
		.ext_c         (ext_c),
		.ext_d         (ext_d),
		.border_colour (border_colour),
		.ear           (ear),
		.lpt_wr        (lpt_wr),
		.midi_wr       (midi_wr)
	);

	mem_page_map u_page_map (
		.mem_addr (mem_addr),
		.lmpr     (lmpr),
		.hmpr     (hmpr),
		.ext_c    (ext_c),
		.ext_d    (ext_d),
		.mem_map  (mem_map)
	);

	midi_tx_timer u_midi (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.midi_wr      (midi_wr),
		.midi_pending (midi_pending),
		.midi_tx      (midi_tx),
		.midi_int     (midi_int)
	);

	// EAR and stereo DAC into the audio outputs
	lpt_dac_mixer u_audio (
		.clk_sys (clk_sys),
		.reset   (reset),
		.lpt_wr  (lpt_wr),
		.ear     (ear),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

// ==== verification/samcoupe_asic_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module samcoupe_asic_checker
	import samcoupe_pkg::*;
(
	input wire                      clk_sys,
	input wire                      reset,
	input wire                      io_req_valid,
	input wire io_req_t             io_req,
	input wire                      io_req_ready,
	input wire                      io_rsp_valid,
	input wire [`SAMC_AUDIO_W-1:0]  audio_l,
	input wire [`SAMC_AUDIO_W-1:0]  audio_r,
	input wire                      midi_tx,
	input wire                      midi_int
);

	int fails = 0;

	// ========================================
	// Handshake
	// ========================================
	a_rsp_single: assert property (@(posedge clk_sys) disable iff (reset)
		io_rsp_valid |=> !io_rsp_valid)
		else begin
			fails++;
			$error("io_rsp_valid stayed high for two cycles in a row");
		end

	// Stalled request holds its values
	a_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(io_req_valid && !io_req_ready) |=> (io_req_valid && $stable(io_req)))
		else begin
			fails++;
			$error("request changed or dropped while io_req_ready was low");
		end

	a_int_tx: assert property (@(posedge clk_sys) disable iff (reset)
		midi_int |-> midi_tx)
		else begin
			fails++;
			$error("midi_int is high without midi_tx");
		end

	// Outputs cleared by reset
	a_reset_low: assert property (@(posedge clk_sys)
		reset |=> (!io_rsp_valid && !midi_tx && !midi_int && audio_l == '0 && audio_r == '0))
		else begin
			fails++;
			$error("an output is not low after reset");
		end

endmodule

bind samcoupe_asic samcoupe_asic_checker u_checker (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.io_req_valid (io_req_valid),
	.io_req       (io_req),
	.io_req_ready (io_req_ready),
	.io_rsp_valid (io_rsp_valid),
	.audio_l      (audio_l),
	.audio_r      (audio_r),
	.midi_tx      (midi_tx),
	.midi_int     (midi_int)
);

`default_nettype wire

// ==== verification/samcoupe_asic_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module samcoupe_asic_monitor
	import samcoupe_pkg::*;
(
	input wire                      clk_sys,
	input wire                      reset,
	input wire                      io_req_valid,
	input wire io_req_t             io_req,
	input wire                      io_req_ready,
	input wire                      io_rsp_valid,
	input wire [`SAMC_DATA_W-1:0]   io_rsp_data,
	input wire [`SAMC_ADDR_W-1:0]   mem_addr,
	input wire mem_map_t            mem_map,
	input wire [3:0]                border_colour,
	input wire [`SAMC_AUDIO_W-1:0]  audio_l,
	input wire [`SAMC_AUDIO_W-1:0]  audio_r,
	input wire                      midi_tx,
	input wire                      midi_int
);

	localparam int INT_CYCLES = `SAMC_MIDI_INT_TICK * `SAMC_CE_1M_DIV;

	logic [7:0] m_lmpr;
	logic [7:0] m_hmpr;
	logic [7:0] m_brdr;
	logic [7:0] m_extc = 'x;
	logic [7:0] m_extd = 'x;
	logic [7:0] m_lpt;
	logic [7:0] m_dac_l;
	logic [7:0] m_dac_r;
	logic       m_stb;
	logic       rsp_due;
	logic [7:0] rsp_exp;
	logic       int_prev = 1'b0;
	int         int_len = 0;
	int         errors = 0;
	int         checks = 0;
	int         test_errors = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         midi_writes = 0;
	int         midi_done = 0;

	// ========================================
	// Reference model
	// ========================================
	function automatic mem_map_t ref_map(input logic [15:0] addr, input logic [7:0] lm,
		input logic [7:0] hm, input logic [7:0] ec, input logic [7:0] ed);
		mem_map_t   m;
		logic [1:0] q;
		logic [4:0] base;
		q      = addr[15:14];
		base   = q[1] ? hm[4:0] : lm[4:0];
		m.page = {4'd0, 5'(base + 5'(q[0]))};
		// Upper half swapped for external RAM
		if (hm[7] && q[1]) begin
			m.page = {1'b1, (q[0] ? ed : ec)};
		end
		m.rom0_sel      = !lm[5] && (q == 2'd0);
		m.rom1_sel      = lm[6] && (q == 2'd3);
		m.write_protect = lm[7] && (q == 2'd0);
		return m;
	endfunction

	function automatic logic [15:0] ref_audio(input logic [7:0] dac, input logic ear);
		int sum;
		sum = int'(dac) * 1028 + (ear ? 131072 : 0);
		return 16'(sum / 8);
	endfunction

	function automatic logic [7:0] ref_read(input logic [7:0] port, input logic int_bit);
		case (port)
			`SAMC_PORT_LMPR: return m_lmpr;
			`SAMC_PORT_HMPR: return m_hmpr;
			`SAMC_PORT_STAT: return int_bit ? 8'hEF : 8'hFF;
			`SAMC_PORT_LPTD, `SAMC_PORT_LPTS: return 8'h00;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("FAIL t=%0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		test_errors++;
		$display("ERROR t=%0t: %s", $time, what);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
		end
		test_errors = 0;
	endtask

	// Model state follows accepted requests
	always @(posedge clk_sys) begin
		if (reset) begin
			m_lmpr      <= '0;
			m_hmpr      <= '0;
			m_brdr      <= '0;
			m_lpt       <= '0;
			m_dac_l     <= '0;
			m_dac_r     <= '0;
			m_stb       <= 1'b0;
			rsp_due     <= 1'b0;
			int_prev    <= 1'b0;
			int_len     <= 0;
			midi_writes <= 0;
			midi_done   <= 0;
		end else begin
			rsp_due <= io_req_valid && io_req_ready && !io_req.write;
			if (io_req_valid && io_req_ready && io_req.write) begin
				case (io_req.addr[7:0])
					`SAMC_PORT_LMPR: m_lmpr <= io_req.data;
					`SAMC_PORT_HMPR: m_hmpr <= io_req.data;
					`SAMC_PORT_BRDR: m_brdr <= io_req.data;
					`SAMC_PORT_EXTC: m_extc <= io_req.data;
					`SAMC_PORT_EXTD: m_extd <= io_req.data;
					`SAMC_PORT_LPTD: m_lpt <= io_req.data;
					`SAMC_PORT_MIDI: midi_writes <= midi_writes + 1;
					`SAMC_PORT_LPTS: begin
						if (io_req.data[0] && !m_stb) begin
							m_dac_l <= m_lpt;
						end
						if (!io_req.data[0] && m_stb) begin
							m_dac_r <= m_lpt;
						end
						m_stb <= io_req.data[0];
					end
					default: ;
				endcase
			end else if (io_req_valid && io_req_ready) begin
				rsp_exp <= ref_read(io_req.addr[7:0], midi_int);
			end
			// One interrupt pulse per transmitted byte
			int_prev <= midi_int;
			int_len  <= midi_int ? int_len + 1 : 0;
			if (int_prev && !midi_int) begin
				midi_done <= midi_done + 1;
				check_value("midi_int pulse length", int_len, INT_CYCLES);
			end
		end
	end

	// ========================================
	// Compare at the falling edge
	// ========================================
	always @(negedge clk_sys) begin
		mem_map_t exp_map;
		exp_map = ref_map(mem_addr, m_lmpr, m_hmpr, m_extc, m_extd);
		check_value("mem_map", 32'(mem_map), 32'(exp_map));
		check_value("border_colour", border_colour, {m_brdr[5], m_brdr[2:0]});
		check_value("audio_l", audio_l, ref_audio(m_dac_l, m_brdr[4]));
		check_value("audio_r", audio_r, ref_audio(m_dac_r, m_brdr[4]));
		check_value("io_rsp_valid", io_rsp_valid, rsp_due);
		if (rsp_due) begin
			check_value("io_rsp_data", io_rsp_data, rsp_exp);
		end
		if (midi_int && !midi_tx) begin
			report_error("midi_int is high while midi_tx is low");
		end
		if (!io_req_ready && !(io_req.write && io_req.addr[7:0] == `SAMC_PORT_MIDI)) begin
			report_error("io_req_ready dropped for a request that is not a MIDI write");
		end
	end

endmodule

`default_nettype wire

// ==== verification/samcoupe_asic_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "samcoupe_cfg.svh"

module samcoupe_asic_tb
	import samcoupe_pkg::*;
();

	localparam int TXN_COUNT       = 400;
	localparam int BYTE_CYCLES     = 321 * `SAMC_CE_1M_DIV;
	localparam int WATCHDOG_CYCLES = 2 * (TXN_COUNT * 4 + 3 * BYTE_CYCLES);

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     io_req_valid;
	io_req_t                  io_req;
	logic                     io_req_ready;
	logic                     io_rsp_valid;
	logic [`SAMC_DATA_W-1:0]  io_rsp_data;
	logic [`SAMC_ADDR_W-1:0]  mem_addr;
	mem_map_t                 mem_map;
	logic [3:0]               border_colour;
	logic [`SAMC_AUDIO_W-1:0] audio_l;
	logic [`SAMC_AUDIO_W-1:0] audio_r;
	logic                     midi_tx;
	logic                     midi_int;
	logic [31:0]              lfsr = 32'ha2a2_b618;

	always #10 clk_sys = ~clk_sys;

	samcoupe_asic UUT (.*);

	samcoupe_asic_monitor u_mon (.*);

	// ========================================
	// Random source and bus tasks
	// ========================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'(rand_bits(8));
	endfunction

	task automatic io_write(input logic [7:0] port, input logic [7:0] data, output int waits);
		logic accepted;
		waits        = 0;
		accepted     = 1'b0;
		io_req_valid <= 1'b1;
		io_req.write <= 1'b1;
		io_req.addr  <= {rand_byte(), port};
		io_req.data  <= data;
		while (!accepted && waits <= BYTE_CYCLES) begin
			@(posedge clk_sys);
			accepted = io_req_ready;
			if (!accepted) begin
				waits++;
			end
		end
		io_req_valid <= 1'b0;
		if (!accepted) begin
			u_mon.report_error("timeout waiting for io_req_ready on a write");
		end
	endtask

	task automatic write_port(input logic [7:0] port, input logic [7:0] data);
		int waits;
		io_write(port, data, waits);
	endtask

	task automatic io_read(input logic [7:0] port, output logic [7:0] data);
		int waits;
		io_req_valid <= 1'b1;
		io_req.write <= 1'b0;
		io_req.addr  <= {rand_byte(), port};
		io_req.data  <= rand_byte();
		@(posedge clk_sys);
		if (!io_req_ready) begin
			u_mon.report_error("a read was not accepted");
		end
		io_req_valid <= 1'b0;
		waits = 0;
		do begin
			@(posedge clk_sys);
			waits++;
		end while (!io_rsp_valid && waits < 4);
		data = io_rsp_data;
		if (!io_rsp_valid) begin
			u_mon.report_error("no response arrived for a read");
		end
	endtask

	task automatic wait_midi(input logic tx, input logic intr, input int limit,
		input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (!(midi_tx == tx && midi_int == intr) && n < limit);
		if (midi_tx != tx || midi_int != intr) begin
			u_mon.report_error({"timeout waiting for ", what});
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================
	initial begin : stimulus
		logic [7:0] v;
		logic [7:0] d;
		int         w2;
		int         w3;
		reset        = 1'b1;
		io_req_valid = 1'b0;
		io_req       = '0;
		mem_addr     = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		// Readback and fixed port values
		write_port(`SAMC_PORT_EXTC, 8'h00);
		write_port(`SAMC_PORT_EXTD, 8'h00);
		repeat (16) begin
			v = rand_byte();
			write_port(`SAMC_PORT_LMPR, v);
			io_read(`SAMC_PORT_LMPR, d);
			u_mon.check_value("LMPR readback", d, v);
			v = rand_byte();
			write_port(`SAMC_PORT_HMPR, v);
			io_read(`SAMC_PORT_HMPR, d);
			u_mon.check_value("HMPR readback", d, v);
			io_read(`SAMC_PORT_LPTD, d);
			u_mon.check_value("port E8 read", d, 8'h00);
			io_read(`SAMC_PORT_LPTS, d);
			u_mon.check_value("port E9 read", d, 8'h00);
			v = rand_byte();
			if (v inside {8'hFA, 8'hFB, 8'hF9, 8'hE8, 8'hE9}) begin
				v = 8'h1F;
			end
			io_read(v, d);
			u_mon.check_value("unmapped port read", d, 8'hFF);
		end
		u_mon.finish_test("register readback");

		// Mapper swept with random addresses
		repeat (8) begin
			write_port(`SAMC_PORT_LMPR, rand_byte());
			write_port(`SAMC_PORT_HMPR, rand_byte());
			write_port(`SAMC_PORT_EXTC, rand_byte());
			write_port(`SAMC_PORT_EXTD, rand_byte());
			repeat (16) begin
				mem_addr <= 16'(rand_bits(16));
				@(posedge clk_sys);
			end
		end
		u_mon.finish_test("page mapper");

		repeat (32) begin
			v = rand_byte();
			case (v[1:0])
				2'd0:       write_port(`SAMC_PORT_LPTD, rand_byte());
				2'd1, 2'd2: write_port(`SAMC_PORT_LPTS, rand_byte());
				default:    write_port(`SAMC_PORT_BRDR, rand_byte());
			endcase
		end
		u_mon.finish_test("DAC and border");

		// ========================================
		// MIDI transmit and back-pressure
		// ========================================
		write_port(`SAMC_PORT_MIDI, rand_byte());
		wait_midi(1'b1, 1'b0, 2 * `SAMC_CE_1M_DIV, "midi_tx to rise");
		wait_midi(1'b1, 1'b1, BYTE_CYCLES, "midi_int to rise");
		io_read(`SAMC_PORT_STAT, d);
		u_mon.check_value("status bit 4 during interrupt", d[4], 1'b0);
		wait_midi(1'b0, 1'b0, BYTE_CYCLES, "MIDI to go idle");
		io_read(`SAMC_PORT_STAT, d);
		u_mon.check_value("status with MIDI idle", d, 8'hFF);
		write_port(`SAMC_PORT_MIDI, rand_byte());
		io_write(`SAMC_PORT_MIDI, rand_byte(), w2);
		u_mon.check_value("midi_tx at accept of byte 2", midi_tx, 1'b1);
		io_write(`SAMC_PORT_MIDI, rand_byte(), w3);
		u_mon.check_value("midi_tx at accept of byte 3", midi_tx, 1'b1);
		if (w2 == 0 || w3 == 0) begin
			u_mon.report_error("a MIDI byte was accepted while another was pending");
		end
		wait_midi(1'b0, 1'b0, 3 * BYTE_CYCLES, "back-to-back bytes to finish");
		repeat (2) @(posedge clk_sys);
		u_mon.check_value("MIDI transmissions", u_mon.midi_done, u_mon.midi_writes);
		u_mon.finish_test("MIDI transmit");

		// Reset in the middle of activity
		write_port(`SAMC_PORT_LMPR, rand_byte() | 8'h01);
		write_port(`SAMC_PORT_HMPR, rand_byte() | 8'h01);
		write_port(`SAMC_PORT_LPTD, 8'hFF);
		write_port(`SAMC_PORT_LPTS, 8'h01);
		write_port(`SAMC_PORT_LPTS, 8'h00);
		write_port(`SAMC_PORT_BRDR, 8'h10);
		write_port(`SAMC_PORT_MIDI, rand_byte());
		wait_midi(1'b1, 1'b0, 2 * `SAMC_CE_1M_DIV, "midi_tx before reset");
		reset <= 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		u_mon.check_value("audio_l after reset", audio_l, 16'h0000);
		u_mon.check_value("audio_r after reset", audio_r, 16'h0000);
		u_mon.check_value("midi_tx after reset", midi_tx, 1'b0);
		u_mon.check_value("io_req_ready after reset", io_req_ready, 1'b1);
		io_read(`SAMC_PORT_LMPR, d);
		u_mon.check_value("LMPR after reset", d, 8'h00);
		io_read(`SAMC_PORT_HMPR, d);
		u_mon.check_value("HMPR after reset", d, 8'h00);
		u_mon.finish_test("mid-run reset");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			u_mon.tests_run, u_mon.tests_failed, u_mon.checks, u_mon.errors,
			UUT.u_checker.fails);
		if (u_mon.errors == 0 && UUT.u_checker.fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== samcoupe_asic.f ====
+incdir+src
src/samcoupe_pkg.sv
src/asic_port_regs.sv
src/mem_page_map.sv
src/midi_tx_timer.sv
src/lpt_dac_mixer.sv
src/samcoupe_asic.sv
verification/samcoupe_asic_checker.sv
verification/samcoupe_asic_monitor.sv
verification/samcoupe_asic_tb.sv
